// File: sources.f
hw/ddr_pad_pkg.sv
hw/dram_cmd_retime.sv
hw/dq_pin_bank.sv
hw/dqs_pin_bank.sv
hw/dram_clock_pad.sv
hw/ddr_pad_top.sv
tb/tb_clock_gen.sv
tb/tb_ddr_pad_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the DDR pad layer testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module tb_ddr_pad_top --Mdir obj_dir -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"
echo "$output" | grep -q "SIMULATION PASSED"

// File: tb/tb_ddr_pad_top.sv
//##########################################################
// testbench for the DDR pad layer: random stimulus every cycle,
// checked mid-phase by assertions against copies of the inputs
//##########################################################
`default_nettype none

module tb_ddr_pad_top
    import ddr_pad_pkg::*;
;

    localparam int DQ_WIDTH    = DEF_DQ_WIDTH;
    localparam int DQS_WIDTH   = DEF_DQS_WIDTH;
    localparam int CLK_PAIRS   = DEF_CLK_PAIRS;
    localparam int PERIOD      = 8;
    localparam int TEST_CYCLES = 400;
    localparam int NUM_TESTS   = 6;

    localparam int CAT_RESET = 0;
    localparam int CAT_CMD   = 1;
    localparam int CAT_WRITE = 2;
    localparam int CAT_DQS   = 3;
    localparam int CAT_READ  = 4;
    localparam int CAT_CLK   = 5;

    logic                 int_drm_clock_buffered;
    logic                 int_drm_clock_90_buffered;
    logic                 system_reset_in;
    logic                 next_cke;
    dram_chip_t           next_s_n;
    logic                 next_ras_n;
    logic                 next_cas_n;
    logic                 next_we_n;
    dram_bank_t           next_ba;
    dram_addr_t           next_a;
    logic [DQ_WIDTH-1:0]  next_dq;
    logic [DQS_WIDTH-1:0] next_dqm;
    logic                 next_dqoe;
    logic [DQS_WIDTH-1:0] next_dqs_high;
    logic [DQS_WIDTH-1:0] next_dqs_low;
    logic [DQ_WIDTH-1:0]  input_dq_high;
    logic [DQ_WIDTH-1:0]  input_dq_low;
    dram_chip_t           dram_cke;
    dram_chip_t           dram_s_n;
    logic                 dram_ras_n;
    logic                 dram_cas_n;
    logic                 dram_we_n;
    dram_bank_t           dram_ba;
    dram_addr_t           dram_a;
    logic [DQ_WIDTH-1:0]  dq_out;
    logic                 dq_oe;
    logic [DQ_WIDTH-1:0]  dq_in;
    logic [DQS_WIDTH-1:0] dqm;
    logic [DQS_WIDTH-1:0] dqs_out;
    logic                 dqs_oe;
    logic [CLK_PAIRS-1:0] dram_clk_p;
    logic [CLK_PAIRS-1:0] dram_clk_n;

    // copies of what the DUT saw at the last edge
    logic                 exp_cke;
    dram_chip_t           exp_s_n;
    logic                 exp_ras_n;
    logic                 exp_cas_n;
    logic                 exp_we_n;
    dram_bank_t           exp_ba;
    dram_addr_t           exp_a;
    logic [DQ_WIDTH-1:0]  exp_dq;
    logic [DQS_WIDTH-1:0] exp_dqm;
    logic                 exp_dqoe;
    logic [DQS_WIDTH-1:0] exp_dqs_high;
    logic [DQS_WIDTH-1:0] exp_dqs_low;
    logic [DQ_WIDTH-1:0]  rise_in;
    logic [DQ_WIDTH-1:0]  fall_in;

    logic   checking;
    integer seed;
    int     fails [0:NUM_TESTS-1];
    int     tests_passed;
    int     tests_failed;

    tb_clock_gen #(.PERIOD (PERIOD), .RESET_CYCLES (3)) u_clock_gen
    (
        .int_drm_clock_buffered    (int_drm_clock_buffered),
        .int_drm_clock_90_buffered (int_drm_clock_90_buffered),
        .system_reset_in           (system_reset_in)
    );

    ddr_pad_top dut (.*);

    task automatic report_mismatch(input int cat, input string name,
                                   input logic [63:0] expected, input logic [63:0] actual);
        fails[cat]++;
        $display("[FAIL] time %0t: %s expected %0h, got %0h", $time, name, expected, actual);
    endtask

    task automatic finish_test(input string name, input int cat);
        if (fails[cat] == 0)
        begin
            $display("test %s: passed", name);
        end
        else
        begin
            $display("test %s: failed with %0d mismatches", name, fails[cat]);
        end
    endtask

    // assertions of a test keep running after its line is printed
    function automatic int count_failed_tests();
        int failed;
        failed = 0;
        for (int cat = 0; cat < NUM_TESTS; cat++)
        begin
            if (fails[cat] != 0)
            begin
                failed++;
            end
        end
        return failed;
    endfunction

    // idle pin state, both inside reset and just after it
    task automatic check_idle();
        assert (dram_s_n == 2'b11) else report_mismatch(CAT_RESET, "dram_s_n", 2'b11, dram_s_n);
        assert (dram_ras_n) else report_mismatch(CAT_RESET, "dram_ras_n", 1, dram_ras_n);
        assert (dram_cas_n) else report_mismatch(CAT_RESET, "dram_cas_n", 1, dram_cas_n);
        assert (dram_we_n) else report_mismatch(CAT_RESET, "dram_we_n", 1, dram_we_n);
        assert (dram_cke == '0) else report_mismatch(CAT_RESET, "dram_cke", 0, dram_cke);
        assert (dq_oe == 1'b0) else report_mismatch(CAT_RESET, "dq_oe", 0, dq_oe);
        assert (dqs_oe == 1'b0) else report_mismatch(CAT_RESET, "dqs_oe", 0, dqs_oe);
        assert (dqm == '0) else report_mismatch(CAT_RESET, "dqm", 0, dqm);
        assert (dqs_out == '0) else report_mismatch(CAT_RESET, "dqs_out", 0, dqs_out);
        assert (dram_clk_p == '0) else report_mismatch(CAT_RESET, "dram_clk_p", 0, dram_clk_p);
        assert (dram_clk_n == '1) else report_mismatch(CAT_RESET, "dram_clk_n", 2'b11, dram_clk_n);
    endtask

    task automatic drive_cycles(input int n);
        repeat (n)
        begin
            @(posedge int_drm_clock_buffered);
            #1;
            next_cke      = 1'($random(seed));
            next_s_n      = dram_chip_t'($random(seed));
            next_ras_n    = 1'($random(seed));
            next_cas_n    = 1'($random(seed));
            next_we_n     = 1'($random(seed));
            next_ba       = dram_bank_t'($random(seed));
            next_a        = dram_addr_t'($random(seed));
            next_dq       = DQ_WIDTH'($random(seed));
            next_dqm      = DQS_WIDTH'($random(seed));
            next_dqoe     = 1'($random(seed));
            next_dqs_high = DQS_WIDTH'($random(seed));
            next_dqs_low  = DQS_WIDTH'($random(seed));
        end
    endtask

    always @(posedge int_drm_clock_buffered)
    begin
        exp_cke      <= next_cke;
        exp_s_n      <= next_s_n;
        exp_ras_n    <= next_ras_n;
        exp_cas_n    <= next_cas_n;
        exp_we_n     <= next_we_n;
        exp_ba       <= next_ba;
        exp_a        <= next_a;
        exp_dq       <= next_dq;
        exp_dqm      <= next_dqm;
        exp_dqoe     <= next_dqoe;
        exp_dqs_high <= next_dqs_high;
        exp_dqs_low  <= next_dqs_low;
        rise_in      <= dq_in;
    end

    always @(negedge int_drm_clock_buffered)
    begin
        fall_in <= dq_in;
    end

    // read data from the pins changes shortly after both edges
    always @(posedge int_drm_clock_buffered or negedge int_drm_clock_buffered)
    begin
        #1;
        dq_in = DQ_WIDTH'($random(seed));
    end

    // command pins one DRAM cycle after the inputs were sampled
    assert property (@(posedge int_drm_clock_buffered) checking |-> (dram_s_n == exp_s_n))
        else report_mismatch(CAT_CMD, "dram_s_n", $sampled(exp_s_n), $sampled(dram_s_n));
    assert property (@(posedge int_drm_clock_buffered) checking |-> (dram_ras_n == exp_ras_n))
        else report_mismatch(CAT_CMD, "dram_ras_n", $sampled(exp_ras_n), $sampled(dram_ras_n));
    assert property (@(posedge int_drm_clock_buffered) checking |-> (dram_cas_n == exp_cas_n))
        else report_mismatch(CAT_CMD, "dram_cas_n", $sampled(exp_cas_n), $sampled(dram_cas_n));
    assert property (@(posedge int_drm_clock_buffered) checking |-> (dram_we_n == exp_we_n))
        else report_mismatch(CAT_CMD, "dram_we_n", $sampled(exp_we_n), $sampled(dram_we_n));
    assert property (@(posedge int_drm_clock_buffered) checking |-> (dram_ba == exp_ba))
        else report_mismatch(CAT_CMD, "dram_ba", $sampled(exp_ba), $sampled(dram_ba));
    assert property (@(posedge int_drm_clock_buffered) checking |-> (dram_a == exp_a))
        else report_mismatch(CAT_CMD, "dram_a", $sampled(exp_a), $sampled(dram_a));
    assert property (@(posedge int_drm_clock_buffered) checking |-> (dram_cke == {2{exp_cke}}))
        else report_mismatch(CAT_CMD, "dram_cke", {2{$sampled(exp_cke)}}, $sampled(dram_cke));

    // high phase, sampled at the 90 degree rising edge
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (dq_out == exp_dq))
        else report_mismatch(CAT_WRITE, "dq_out", $sampled(exp_dq), $sampled(dq_out));
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (dq_oe == exp_dqoe))
        else report_mismatch(CAT_WRITE, "dq_oe", $sampled(exp_dqoe), $sampled(dq_oe));
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (dqm == exp_dqm))
        else report_mismatch(CAT_WRITE, "dqm", $sampled(exp_dqm), $sampled(dqm));
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (dqs_out == exp_dqs_high))
        else report_mismatch(CAT_DQS, "dqs_out", $sampled(exp_dqs_high), $sampled(dqs_out));
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (dqs_oe == exp_dqoe))
        else report_mismatch(CAT_DQS, "dqs_oe", $sampled(exp_dqoe), $sampled(dqs_oe));
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (input_dq_high == rise_in))
        else report_mismatch(CAT_READ, "input_dq_high", $sampled(rise_in),
                             $sampled(input_dq_high));
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (dram_clk_p == '1))
        else report_mismatch(CAT_CLK, "dram_clk_p", 2'b11, $sampled(dram_clk_p));
    assert property (@(posedge int_drm_clock_90_buffered) checking |-> (dram_clk_n == '0))
        else report_mismatch(CAT_CLK, "dram_clk_n", 0, $sampled(dram_clk_n));

    // low phase, sampled at the 90 degree falling edge
    assert property (@(negedge int_drm_clock_90_buffered) checking |-> (dq_out == exp_dq))
        else report_mismatch(CAT_WRITE, "dq_out", $sampled(exp_dq), $sampled(dq_out));
    assert property (@(negedge int_drm_clock_90_buffered) checking |-> (dqs_out == exp_dqs_low))
        else report_mismatch(CAT_DQS, "dqs_out", $sampled(exp_dqs_low), $sampled(dqs_out));
    assert property (@(negedge int_drm_clock_90_buffered) checking |-> (input_dq_low == fall_in))
        else report_mismatch(CAT_READ, "input_dq_low", $sampled(fall_in),
                             $sampled(input_dq_low));
    assert property (@(negedge int_drm_clock_90_buffered) checking |-> (dram_clk_p == '0))
        else report_mismatch(CAT_CLK, "dram_clk_p", 0, $sampled(dram_clk_p));
    assert property (@(negedge int_drm_clock_90_buffered) checking |-> (dram_clk_n == '1))
        else report_mismatch(CAT_CLK, "dram_clk_n", 2'b11, $sampled(dram_clk_n));

    initial
    begin
        #(TEST_CYCLES * PERIOD + 200);
        $display("watchdog expired before the test sequence completed");
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        seed          = 32'heae5d59a;
        checking      = 1'b0;
        tests_passed  = 0;
        tests_failed  = 0;
        fails         = '{default: 0};
        next_cke      = 1'b0;
        next_s_n      = '1;
        next_ras_n    = 1'b1;
        next_cas_n    = 1'b1;
        next_we_n     = 1'b1;
        next_ba       = '0;
        next_a        = '0;
        next_dq       = '0;
        next_dqm      = '0;
        next_dqoe     = 1'b0;
        next_dqs_high = '0;
        next_dqs_low  = '0;
        dq_in         = '0;

        repeat (2) @(posedge int_drm_clock_buffered);
        #1;
        check_idle();
        @(negedge system_reset_in);
        #1;
        check_idle();
        finish_test("reset", CAT_RESET);

        // first full cycle out of reset loads real values everywhere
        @(posedge int_drm_clock_buffered);
        #1;
        checking = 1'b1;

        drive_cycles(100);
        finish_test("commands", CAT_CMD);
        drive_cycles(100);
        finish_test("writes", CAT_WRITE);
        drive_cycles(100);
        finish_test("strobes", CAT_DQS);
        drive_cycles(90);
        finish_test("reads", CAT_READ);
        drive_cycles(10);
        repeat (2) @(posedge int_drm_clock_buffered);
        finish_test("clock pads", CAT_CLK);

        tests_failed = count_failed_tests();
        tests_passed = NUM_TESTS - tests_failed;
        $display("tests done: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
//##########################################################
// testbench clocks: DRAM clock, its 90 degree copy and reset
//##########################################################
`default_nettype none

module tb_clock_gen
#(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 3
)
(
    output logic int_drm_clock_buffered,
    output logic int_drm_clock_90_buffered,
    output logic system_reset_in
);

    initial
    begin
        int_drm_clock_buffered = 1'b0;
        forever #(PERIOD / 2) int_drm_clock_buffered = ~int_drm_clock_buffered;
    end

    // quarter period behind the DRAM clock
    initial
    begin
        int_drm_clock_90_buffered = 1'b0;
        #(PERIOD / 4);
        forever #(PERIOD / 2) int_drm_clock_90_buffered = ~int_drm_clock_90_buffered;
    end

    // release just after a rising edge, clear of both clock edges
    initial
    begin
        system_reset_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge int_drm_clock_buffered);
        #1;
        system_reset_in = 1'b0;
    end

endmodule

`default_nettype wire

// File: hw/ddr_pad_top.sv
//##########################################################
// DDR pad layer top: joins the command, data, strobe and clock
// pin banks; the board wrapper adds the tristate pad buffers
//##########################################################
`default_nettype none

module ddr_pad_top
    import ddr_pad_pkg::*;
#(
    parameter int DQ_WIDTH  = DEF_DQ_WIDTH,
    parameter int DQS_WIDTH = DEF_DQS_WIDTH,
    parameter int CLK_PAIRS = DEF_CLK_PAIRS
)
(
    input  wire logic                 int_drm_clock_buffered,
    input  wire logic                 int_drm_clock_90_buffered,
    input  wire logic                 system_reset_in,

    // controller command side
    input  wire logic                 next_cke,
    input  wire dram_chip_t           next_s_n,
    input  wire logic                 next_ras_n,
    input  wire logic                 next_cas_n,
    input  wire logic                 next_we_n,
    input  wire dram_bank_t           next_ba,
    input  wire dram_addr_t           next_a,

    // controller write data and strobes
    input  wire logic [DQ_WIDTH-1:0]  next_dq,
    input  wire logic [DQS_WIDTH-1:0] next_dqm,
    input  wire logic                 next_dqoe,
    input  wire logic [DQS_WIDTH-1:0] next_dqs_high,
    input  wire logic [DQS_WIDTH-1:0] next_dqs_low,

    // read data back to the controller
    output logic [DQ_WIDTH-1:0]       input_dq_high,
    output logic [DQ_WIDTH-1:0]       input_dq_low,

    // command pins
    output dram_chip_t                dram_cke,
    output dram_chip_t                dram_s_n,
    output logic                      dram_ras_n,
    output logic                      dram_cas_n,
    output logic                      dram_we_n,
    output dram_bank_t                dram_ba,
    output dram_addr_t                dram_a,

    // data and strobe pins, split for the pad buffer
    output logic [DQ_WIDTH-1:0]       dq_out,
    output logic                      dq_oe,
    input  wire logic [DQ_WIDTH-1:0]  dq_in,
    output logic [DQS_WIDTH-1:0]      dqm,
    output logic [DQS_WIDTH-1:0]      dqs_out,
    output logic                      dqs_oe,

    // forwarded clock pins
    output logic [CLK_PAIRS-1:0]      dram_clk_p,
    output logic [CLK_PAIRS-1:0]      dram_clk_n
);

    dram_cmd_retime u_cmd
    (
        .int_drm_clock_buffered    (int_drm_clock_buffered),
        .int_drm_clock_90_buffered (int_drm_clock_90_buffered),
        .system_reset_in           (system_reset_in),
        .next_cke                  (next_cke),
        .next_s_n                  (next_s_n),
        .next_ras_n                (next_ras_n),
        .next_cas_n                (next_cas_n),
        .next_we_n                 (next_we_n),
        .next_ba                   (next_ba),
        .next_a                    (next_a),
        .dram_cke                  (dram_cke),
        .dram_s_n                  (dram_s_n),
        .dram_ras_n                (dram_ras_n),
        .dram_cas_n                (dram_cas_n),
        .dram_we_n                 (dram_we_n),
        .dram_ba                   (dram_ba),
        .dram_a                    (dram_a)
    );

    dq_pin_bank
    #(
        .DQ_WIDTH  (DQ_WIDTH),
        .DQS_WIDTH (DQS_WIDTH)
    )
    u_dq
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .next_dq                (next_dq),
        .next_dqm               (next_dqm),
        .next_dqoe              (next_dqoe),
        .dq_in                  (dq_in),
        .dq_out                 (dq_out),
        .dq_oe                  (dq_oe),
        .dqm                    (dqm),
        .input_dq_high          (input_dq_high),
        .input_dq_low           (input_dq_low)
    );

    // dqs shares the data enable so strobe and data turn around together
    dqs_pin_bank
    #(
        .DQS_WIDTH (DQS_WIDTH)
    )
    u_dqs
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .next_dqs_high          (next_dqs_high),
        .next_dqs_low           (next_dqs_low),
        .next_dqoe              (next_dqoe),
        .dqs_out                (dqs_out),
        .dqs_oe                 (dqs_oe)
    );

    dram_clock_pad
    #(
        .CLK_PAIRS (CLK_PAIRS)
    )
    u_clk
    (
        .int_drm_clock_buffered (int_drm_clock_buffered),
        .system_reset_in        (system_reset_in),
        .dram_clk_p             (dram_clk_p),
        .dram_clk_n             (dram_clk_n)
    );

endmodule

`default_nettype wire

// File: hw/dram_clock_pad.sv
//##########################################################
// differential DRAM clock pairs built from dual-edge registers
//##########################################################
`default_nettype none

module dram_clock_pad
    import ddr_pad_pkg::*;
#(
    parameter int CLK_PAIRS = DEF_CLK_PAIRS
)
(
    input  wire logic            int_drm_clock_buffered,
    input  wire logic            system_reset_in,
    output logic [CLK_PAIRS-1:0] dram_clk_p,
    output logic [CLK_PAIRS-1:0] dram_clk_n
);

    ddr_phase_e phase;

    logic [CLK_PAIRS-1:0] p_rise;
    logic [CLK_PAIRS-1:0] p_fall;
    logic [CLK_PAIRS-1:0] n_rise;
    logic [CLK_PAIRS-1:0] n_fall;

    // same register pair as the data pins, so the clock lines up with dq
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            p_rise <= '0;
            n_rise <= '1;
        end
        else
        begin
            p_rise <= '1;
            n_rise <= '0;
        end
    end

    always_ff @(negedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            p_fall <= '0;
            n_fall <= '1;
        end
        else
        begin
            p_fall <= '0;
            n_fall <= '1;
        end
    end

    assign phase      = int_drm_clock_buffered ? PHASE_HIGH : PHASE_LOW;
    assign dram_clk_p = (phase == PHASE_HIGH) ? p_rise : p_fall;
    assign dram_clk_n = (phase == PHASE_HIGH) ? n_rise : n_fall;

endmodule

`default_nettype wire

// File: hw/dqs_pin_bank.sv
//##########################################################
// DQS pin bank: DDR strobe output with a registered enable
//##########################################################
`default_nettype none

module dqs_pin_bank
    import ddr_pad_pkg::*;
#(
    parameter int DQS_WIDTH = DEF_DQS_WIDTH
)
(
    input  wire logic                 int_drm_clock_buffered,
    input  wire logic                 system_reset_in,
    input  wire logic [DQS_WIDTH-1:0] next_dqs_high,
    input  wire logic [DQS_WIDTH-1:0] next_dqs_low,
    input  wire logic                 next_dqoe,
    output logic [DQS_WIDTH-1:0]      dqs_out,
    output logic                      dqs_oe
);

    ddr_phase_e phase;

    logic [DQS_WIDTH-1:0] dqs_high_q;
    logic [DQS_WIDTH-1:0] dqs_low_q;
    logic [DQS_WIDTH-1:0] dqs_low_fall;

    // both halves are taken together at the rising edge
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dqs_high_q <= '0;
            dqs_low_q  <= '0;
            dqs_oe     <= 1'b0;
        end
        else
        begin
            dqs_high_q <= next_dqs_high;
            dqs_low_q  <= next_dqs_low;
            dqs_oe     <= next_dqoe;
        end
    end

    // low half moves across to the falling edge register
    always_ff @(negedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dqs_low_fall <= '0;
        end
        else
        begin
            dqs_low_fall <= dqs_low_q;
        end
    end

    assign phase   = int_drm_clock_buffered ? PHASE_HIGH : PHASE_LOW;
    assign dqs_out = (phase == PHASE_HIGH) ? dqs_high_q : dqs_low_fall;

endmodule

`default_nettype wire

// File: hw/dq_pin_bank.sv
//##########################################################
// DQ pin bank: SDR write data held for a whole cycle and
// DDR read capture into a high and a low word
//##########################################################
`default_nettype none

module dq_pin_bank
    import ddr_pad_pkg::*;
#(
    parameter int DQ_WIDTH  = DEF_DQ_WIDTH,
    parameter int DQS_WIDTH = DEF_DQS_WIDTH
)
(
    input  wire logic                 int_drm_clock_buffered,
    input  wire logic                 system_reset_in,
    input  wire logic [DQ_WIDTH-1:0]  next_dq,
    input  wire logic [DQS_WIDTH-1:0] next_dqm,
    input  wire logic                 next_dqoe,
    input  wire logic [DQ_WIDTH-1:0]  dq_in,
    output logic [DQ_WIDTH-1:0]       dq_out,
    output logic                      dq_oe,
    output logic [DQS_WIDTH-1:0]      dqm,
    output logic [DQ_WIDTH-1:0]       input_dq_high,
    output logic [DQ_WIDTH-1:0]       input_dq_low
);

    ddr_phase_e phase;

    logic [DQ_WIDTH-1:0] dq_rise;
    logic [DQ_WIDTH-1:0] dq_fall;

    // write word, enable and masks all load at the rising edge
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dq_rise <= '0;
            dq_oe   <= 1'b0;
            dqm     <= '0;
        end
        else
        begin
            dq_rise <= next_dq;
            dq_oe   <= next_dqoe;
            dqm     <= next_dqm;
        end
    end

    // keep copy so the low half drives the same word
    always_ff @(negedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dq_fall <= '0;
        end
        else
        begin
            dq_fall <= dq_rise;
        end
    end

    // read capture, high word on the rising edge
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            input_dq_high <= '0;
        end
        else
        begin
            input_dq_high <= dq_in;
        end
    end

    // low word on the falling edge
    always_ff @(negedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            input_dq_low <= '0;
        end
        else
        begin
            input_dq_low <= dq_in;
        end
    end

    assign phase  = int_drm_clock_buffered ? PHASE_HIGH : PHASE_LOW;
    assign dq_out = (phase == PHASE_HIGH) ? dq_rise : dq_fall;

endmodule

`default_nettype wire

// File: hw/dram_cmd_retime.sv
//##########################################################
// command and address retiming toward the DRAM pins
// registered on the DRAM clock, launched on the 90 degree clock
//##########################################################
`default_nettype none

module dram_cmd_retime
    import ddr_pad_pkg::*;
(
    input  wire logic       int_drm_clock_buffered,
    input  wire logic       int_drm_clock_90_buffered,
    input  wire logic       system_reset_in,
    input  wire logic       next_cke,
    input  wire dram_chip_t next_s_n,
    input  wire logic       next_ras_n,
    input  wire logic       next_cas_n,
    input  wire logic       next_we_n,
    input  wire dram_bank_t next_ba,
    input  wire dram_addr_t next_a,
    output dram_chip_t      dram_cke,
    output dram_chip_t      dram_s_n,
    output logic            dram_ras_n,
    output logic            dram_cas_n,
    output logic            dram_we_n,
    output dram_bank_t      dram_ba,
    output dram_addr_t      dram_a
);

    dram_chip_t hold_s_n;
    logic       hold_ras_n;
    logic       hold_cas_n;
    logic       hold_we_n;
    dram_bank_t hold_ba;
    dram_addr_t hold_a;

    // one flop per chip so each can sit next to its own pad
    logic cke_0;
    logic cke_1;

    // hold stage, resets to deselect so release cannot issue a command
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            hold_s_n   <= '1;
            hold_ras_n <= 1'b1;
            hold_cas_n <= 1'b1;
            hold_we_n  <= 1'b1;
            hold_ba    <= '0;
            hold_a     <= '0;
        end
        else
        begin
            hold_s_n   <= next_s_n;
            hold_ras_n <= next_ras_n;
            hold_cas_n <= next_cas_n;
            hold_we_n  <= next_we_n;
            hold_ba    <= next_ba;
            hold_a     <= next_a;
        end
    end

    // cke is slow, so it stays on the unshifted clock like the strobes
    always_ff @(posedge int_drm_clock_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            cke_0 <= 1'b0;
            cke_1 <= 1'b0;
        end
        else
        begin
            cke_0 <= next_cke;
            cke_1 <= next_cke;
        end
    end

    // launch a quarter cycle later so the pins are centred on the DRAM clock edge
    always_ff @(posedge int_drm_clock_90_buffered or posedge system_reset_in)
    begin
        if (system_reset_in)
        begin
            dram_s_n   <= '1;
            dram_ras_n <= 1'b1;
            dram_cas_n <= 1'b1;
            dram_we_n  <= 1'b1;
            dram_ba    <= '0;
            dram_a     <= '0;
        end
        else
        begin
            dram_s_n   <= hold_s_n;
            dram_ras_n <= hold_ras_n;
            dram_cas_n <= hold_cas_n;
            dram_we_n  <= hold_we_n;
            dram_ba    <= hold_ba;
            dram_a     <= hold_a;
        end
    end

    assign dram_cke = {cke_1, cke_0};

endmodule

`default_nettype wire

// File: hw/ddr_pad_pkg.sv
//##########################################################
// shared widths, default sizes and the clock phase type
// for the DDR pad layer; imported by the pin bank modules
//##########################################################
`default_nettype none

package ddr_pad_pkg;

    // row and column address bus
    typedef logic [12:0] dram_addr_t;

    // bank address
    typedef logic [1:0] dram_bank_t;

    // one bit per chip, used for select and cke
    typedef logic [1:0] dram_chip_t;

    // default data width as seen by the controller
    localparam int DEF_DQ_WIDTH = 32;

    // one strobe and one mask per byte lane
    localparam int DEF_DQS_WIDTH = DEF_DQ_WIDTH / 8;

    // forwarded clock pairs, one per chip
    localparam int DEF_CLK_PAIRS = 2;

    // which half of the DRAM clock is driving the pins
    typedef enum logic
    {
        PHASE_LOW  = 1'b0,
        PHASE_HIGH = 1'b1
    } ddr_phase_e;

endpackage

`default_nettype wire
